/* design/fetch_pkg.sv */
package fetch_pkg;

    // Datapath width for addresses and instruction words
    localparam int XLEN = 32;

    // Byte offset bits inside one 32-byte cache line
    localparam int LINE_OFFSET_BITS = 5;

    // Distance in bytes from slot 0 to slot 1
    localparam int unsigned INSTR_BYTES = 4;

    // Read mask for a full 32-bit word
    localparam logic [3:0] FULL_MASK = 4'b1111;

    // Immediate widths of the branch and jump formats, bit 0 included
    localparam int IMM_B_BITS = 13;
    localparam int IMM_J_BITS = 21;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] instr_t;

    // First fetch address out of reset
    localparam addr_t RESET_PC = 32'hAAAAA000;

    // Major opcodes that matter to the front end
    // Anything not listed folds into OTHER
    typedef enum logic [6:0] {
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        OTHER  = 7'b0000000
    } opcode_e;

endpackage

/* design/fetch_request.sv */
`timescale 1ns/1ps

module fetch_request import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall_backend,
    input  logic       branch_mispredict,
    input  logic       flush,
    input  addr_t      correct_target,
    input  logic       icache_resp,
    input  logic       queue_almost_full,
    input  logic       hold,
    input  logic       s2_valid,
    input  addr_t      next_pc,
    output addr_t      icache_addr,
    output logic [3:0] icache_rmask,
    output addr_t      icache_addr_1,
    output logic [3:0] icache_rmask_1,
    output logic       s1_valid,
    output addr_t      s1_pc,
    output logic       resp_taken,
    output logic       pair_ok
);

    // S1 holds the address whose response is awaited
    addr_t s1_pc_r;
    logic  s1_valid_r;

    // Request decided this cycle
    logic  send;
    addr_t req_pc;
    addr_t req_pc_1;
    logic  port_active;

    // Slot 1 address of the pair now in S1
    addr_t s1_pc_plus;

    // True when both addresses index the same cache line
    function automatic logic same_line(addr_t a, addr_t b);
        return a[XLEN-1:LINE_OFFSET_BITS] == b[XLEN-1:LINE_OFFSET_BITS];
    endfunction

    // A response only counts against a live request
    assign resp_taken = s1_valid_r && icache_resp;

    // Request selection, highest priority first
    always_comb begin
        send   = 1'b0;
        req_pc = s1_pc_r;
        if (branch_mispredict || flush) begin
            // Redirect from the backend
            send   = 1'b1;
            req_pc = correct_target;
        end else if (!s1_valid_r) begin
            if (hold && !stall_backend) begin
                // Captured pair goes out now, so fetch what follows it
                send   = 1'b1;
                req_pc = next_pc;
            end else if (!s2_valid) begin
                // Nothing in flight at all, reissue the S1 address
                send   = 1'b1;
                req_pc = s1_pc_r;
            end
        end else if (resp_taken && !stall_backend) begin
            // Pipelined advance in the response cycle
            send   = 1'b1;
            req_pc = next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_r <= 1'b1;
            s1_pc_r    <= RESET_PC;
        end else if (send) begin
            s1_valid_r <= 1'b1;
            s1_pc_r    <= req_pc;
        end else if (resp_taken) begin
            // Response went into the capture side under stall
            // PC stays put so pair_ok still refers to the held pair
            s1_valid_r <= 1'b0;
        end
    end

    // Port 0 sees a new request in the same cycle
    assign port_active  = send || s1_valid_r;
    assign icache_addr  = req_pc;
    assign icache_rmask = port_active ? FULL_MASK : 4'b0000;

    // Port 1 reads PC+4 only inside the same line
    assign req_pc_1       = req_pc + addr_t'(INSTR_BYTES);
    assign icache_addr_1  = req_pc_1;
    assign icache_rmask_1 = (port_active && same_line(req_pc, req_pc_1))
                            ? FULL_MASK : 4'b0000;

    // Pair test for the responding or held pair
    assign s1_pc_plus = s1_pc_r + addr_t'(INSTR_BYTES);
    assign pair_ok    = same_line(s1_pc_r, s1_pc_plus) && !queue_almost_full;

    assign s1_valid = s1_valid_r;
    assign s1_pc    = s1_pc_r;

endmodule

/* design/slot_predecode.sv */
`timescale 1ns/1ps

module slot_predecode import fetch_pkg::*; (
    input  instr_t instr,
    input  addr_t  pc,
    output logic   is_cti,
    output logic   taken,
    output addr_t  target
);

    opcode_e                op;
    logic [IMM_B_BITS-1:0]  imm_b;
    logic [IMM_J_BITS-1:0]  imm_j;
    addr_t                  target_b;
    addr_t                  target_j;

    // Fold the major opcode into the small set the front end cares about
    always_comb begin
        case (instr[6:0])
            BRANCH:  op = BRANCH;
            JAL:     op = JAL;
            JALR:    op = JALR;
            default: op = OTHER;
        endcase
    end

    // B-type immediate, halfword aligned
    assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // J-type immediate, halfword aligned
    assign imm_j = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Sign extend and add to the slot PC
    assign target_b = pc + {{(XLEN-IMM_B_BITS){imm_b[IMM_B_BITS-1]}}, imm_b};
    assign target_j = pc + {{(XLEN-IMM_J_BITS){imm_j[IMM_J_BITS-1]}}, imm_j};

    assign is_cti = (op != OTHER);

    // Static prediction per opcode
    always_comb begin
        case (op)
            BRANCH: begin
                // Backward taken, forward not taken
                taken  = imm_b[IMM_B_BITS-1];
                target = target_b;
            end
            JAL: begin
                taken  = 1'b1;
                target = target_j;
            end
            default: begin
                // JALR target is unknown here, so fall through
                taken  = 1'b0;
                target = pc + addr_t'(INSTR_BYTES);
            end
        endcase
    end

endmodule

/* design/fetch_capture.sv */
`timescale 1ns/1ps

module fetch_capture import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall_backend,
    input  logic   branch_mispredict,
    input  logic   flush,
    input  logic   s1_valid,
    input  addr_t  s1_pc,
    input  logic   resp_taken,
    input  logic   pair_ok,
    input  instr_t icache_rdata,
    input  instr_t icache_rdata_1,
    input  logic   icache_resp_1,
    input  logic   taken_0,
    input  addr_t  target_0,
    input  logic   taken_1,
    input  addr_t  target_1,
    input  logic   is_cti_0,
    input  logic   is_cti_1,
    output logic   hold,
    output logic   s2_valid,
    output addr_t  slot_pc,
    output instr_t slot_instr,
    output instr_t slot_instr_1,
    output addr_t  next_pc,
    output instr_t fetch_instr,
    output addr_t  fetch_pc,
    output logic   fetch_valid,
    output logic   fetch_predicted_taken,
    output addr_t  fetch_predicted_target,
    output instr_t fetch_instr_1,
    output addr_t  fetch_pc_1,
    output logic   fetch_valid_1,
    output logic   fetch_predicted_taken_1,
    output addr_t  fetch_predicted_target_1
);

    // S2 control
    logic   hold_r;
    logic   s2_valid_r;
    logic   s2_valid_1_r;

    // Pair captured while the backend stalls
    addr_t  s2_pc_r;
    instr_t s2_instr_r;
    instr_t s2_instr_1_r;

    logic   redirect;
    logic   slot_1_resp;
    logic   taken_slot_0;
    logic   pair_live;

    assign redirect = branch_mispredict || flush;

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            hold_r       <= 1'b0;
            s2_valid_r   <= 1'b0;
            s2_valid_1_r <= 1'b0;
        end else if (resp_taken) begin
            s2_valid_r   <= 1'b1;
            hold_r       <= stall_backend;
            s2_valid_1_r <= icache_resp_1;
        end else if (!stall_backend) begin
            // Whatever S2 had was presented this cycle
            hold_r       <= 1'b0;
            s2_valid_r   <= 1'b0;
            s2_valid_1_r <= 1'b0;
        end
    end

    // Payload only loads under stall, live data is used otherwise
    always_ff @(posedge clk) begin
        if (resp_taken && stall_backend) begin
            s2_pc_r      <= s1_pc;
            s2_instr_r   <= icache_rdata;
            s2_instr_1_r <= icache_rdata_1;
        end
    end

    // Held pair wins over the live response
    assign slot_pc      = hold_r ? s2_pc_r : s1_pc;
    assign slot_instr   = hold_r ? s2_instr_r : icache_rdata;
    assign slot_instr_1 = hold_r ? s2_instr_1_r : icache_rdata_1;
    assign slot_1_resp  = hold_r ? s2_valid_1_r : icache_resp_1;

    // Taken CTI in slot 0 kills slot 1
    assign taken_slot_0 = is_cti_0 && taken_0;
    assign pair_live    = pair_ok && slot_1_resp && !taken_slot_0;

    // Four-way next PC rule
    always_comb begin
        if (taken_slot_0)
            next_pc = target_0;
        else if (pair_live && is_cti_1 && taken_1)
            next_pc = target_1;
        else if (pair_live)
            next_pc = slot_pc + addr_t'(2 * INSTR_BYTES);
        else
            next_pc = slot_pc + addr_t'(INSTR_BYTES);
    end

    // Live path needs S1 valid, held path is valid by construction
    assign fetch_valid = !redirect && !stall_backend && (hold_r || (s1_valid && resp_taken));
    assign fetch_valid_1 = fetch_valid && pair_live;

    assign fetch_instr            = slot_instr;
    assign fetch_pc               = slot_pc;
    assign fetch_predicted_taken  = fetch_valid && taken_slot_0;
    assign fetch_predicted_target = target_0;

    assign fetch_instr_1            = slot_instr_1;
    assign fetch_pc_1               = slot_pc + addr_t'(INSTR_BYTES);
    assign fetch_predicted_taken_1  = fetch_valid_1 && is_cti_1 && taken_1;
    assign fetch_predicted_target_1 = target_1;

    assign hold     = hold_r;
    assign s2_valid = s2_valid_r;

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall_backend,
    input  logic       queue_almost_full,
    input  logic       branch_mispredict,
    input  logic       flush,
    input  addr_t      correct_target,
    // Cache port 0
    output addr_t      icache_addr,
    output logic [3:0] icache_rmask,
    input  instr_t     icache_rdata,
    input  logic       icache_resp,
    // Cache port 1 at PC+4
    output addr_t      icache_addr_1,
    output logic [3:0] icache_rmask_1,
    input  instr_t     icache_rdata_1,
    input  logic       icache_resp_1,
    // Slot 0 to the instruction queue
    output instr_t     fetch_instr,
    output addr_t      fetch_pc,
    output logic       fetch_valid,
    output logic       fetch_predicted_taken,
    output addr_t      fetch_predicted_target,
    // Slot 1 to the instruction queue
    output instr_t     fetch_instr_1,
    output addr_t      fetch_pc_1,
    output logic       fetch_valid_1,
    output logic       fetch_predicted_taken_1,
    output addr_t      fetch_predicted_target_1
);

    // Request side to capture side
    logic   s1_valid;
    addr_t  s1_pc;
    logic   resp_taken;
    logic   pair_ok;

    // Capture side back to request side
    logic   hold;
    logic   s2_valid;
    addr_t  next_pc;

    // Presented pair and its predecode results
    addr_t  slot_pc;
    addr_t  slot_pc_1;
    instr_t slot_instr;
    instr_t slot_instr_1;
    logic   is_cti_0;
    logic   is_cti_1;
    logic   taken_0;
    logic   taken_1;
    addr_t  target_0;
    addr_t  target_1;

    fetch_request u_request (
        .clk               (clk),
        .rst               (rst),
        .stall_backend     (stall_backend),
        .branch_mispredict (branch_mispredict),
        .flush             (flush),
        .correct_target    (correct_target),
        .icache_resp       (icache_resp),
        .queue_almost_full (queue_almost_full),
        .hold              (hold),
        .s2_valid          (s2_valid),
        .next_pc           (next_pc),
        .icache_addr       (icache_addr),
        .icache_rmask      (icache_rmask),
        .icache_addr_1     (icache_addr_1),
        .icache_rmask_1    (icache_rmask_1),
        .s1_valid          (s1_valid),
        .s1_pc             (s1_pc),
        .resp_taken        (resp_taken),
        .pair_ok           (pair_ok)
    );

    // Slot 1 sits one word above slot 0
    assign slot_pc_1 = fetch_pc_1;

    slot_predecode u_predecode_0 (
        .instr  (slot_instr),
        .pc     (slot_pc),
        .is_cti (is_cti_0),
        .taken  (taken_0),
        .target (target_0)
    );

    slot_predecode u_predecode_1 (
        .instr  (slot_instr_1),
        .pc     (slot_pc_1),
        .is_cti (is_cti_1),
        .taken  (taken_1),
        .target (target_1)
    );

    fetch_capture u_capture (
        .clk                      (clk),
        .rst                      (rst),
        .stall_backend            (stall_backend),
        .branch_mispredict        (branch_mispredict),
        .flush                    (flush),
        .s1_valid                 (s1_valid),
        .s1_pc                    (s1_pc),
        .resp_taken               (resp_taken),
        .pair_ok                  (pair_ok),
        .icache_rdata             (icache_rdata),
        .icache_rdata_1           (icache_rdata_1),
        .icache_resp_1            (icache_resp_1),
        .taken_0                  (taken_0),
        .target_0                 (target_0),
        .taken_1                  (taken_1),
        .target_1                 (target_1),
        .is_cti_0                 (is_cti_0),
        .is_cti_1                 (is_cti_1),
        .hold                     (hold),
        .s2_valid                 (s2_valid),
        .slot_pc                  (slot_pc),
        .slot_instr               (slot_instr),
        .slot_instr_1             (slot_instr_1),
        .next_pc                  (next_pc),
        .fetch_instr              (fetch_instr),
        .fetch_pc                 (fetch_pc),
        .fetch_valid              (fetch_valid),
        .fetch_predicted_taken    (fetch_predicted_taken),
        .fetch_predicted_target   (fetch_predicted_target),
        .fetch_instr_1            (fetch_instr_1),
        .fetch_pc_1               (fetch_pc_1),
        .fetch_valid_1            (fetch_valid_1),
        .fetch_predicted_taken_1  (fetch_predicted_taken_1),
        .fetch_predicted_target_1 (fetch_predicted_target_1)
    );

endmodule

/* bench/icache_model.sv */
`timescale 1ns/1ps

module icache_model import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      addr,
    input  logic [3:0] rmask,
    output instr_t     rdata,
    output logic       resp,
    input  addr_t      addr_1,
    input  logic [3:0] rmask_1,
    output instr_t     rdata_1,
    output logic       resp_1
);

    // Eight-word program window, written by the testbench
    addr_t  prog_base;
    instr_t prog [8];

    // Program word inside the window, address-derived OP-IMM word elsewhere
    function automatic instr_t word_at(addr_t a);
        addr_t off;
        off = a - prog_base;
        if (off < 32)
            return prog[off[4:2]];
        return {a[31:7] ^ {a[6:0], 18'b0}, 7'h13};
    endfunction

    // One cycle of latency on both ports
    always_ff @(posedge clk) begin
        if (rst) begin
            resp   <= 1'b0;
            resp_1 <= 1'b0;
        end else begin
            resp   <= (rmask != 4'b0000);
            resp_1 <= (rmask != 4'b0000) && (rmask_1 != 4'b0000);
        end
        if (rmask != 4'b0000)
            rdata <= word_at(addr);
        if (rmask_1 != 4'b0000)
            rdata_1 <= word_at(addr_1);
    end

endmodule

/* bench/fetch_assertions.sv */
`timescale 1ns/1ps

module fetch_assertions (
    input logic        clk,
    input logic        rst,
    input logic        stall_backend,
    input logic        queue_almost_full,
    input logic        flush,
    input logic [31:0] correct_target,
    input logic        s1_valid,
    input logic [31:0] s1_pc,
    input logic        hold,
    input logic        fetch_valid,
    input logic [31:0] fetch_pc,
    input logic        fetch_valid_1,
    input logic [31:0] fetch_pc_1
);

    // Slot 1 rides with slot 0, inside the same line and with queue room
    a_pair_order: assert property (@(posedge clk) disable iff (rst)
        fetch_valid_1 |-> fetch_valid && !queue_almost_full
                          && fetch_pc_1[31:5] == fetch_pc[31:5])
        else $error("slot 1 valid without slot 0 in its line");

    // Flush kills the output in its own cycle and reloads S1 from the target
    a_flush_kill: assert property (@(posedge clk) disable iff (rst)
        flush |=> $past(!fetch_valid) && s1_valid && s1_pc == $past(correct_target))
        else $error("flush did not kill the output or redirect S1");

    // Stalled backend sees nothing, and S1 stays empty while a pair is held
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall_backend |-> !fetch_valid && !(hold && s1_valid))
        else $error("fetch_valid high or S1 refilled while stalled");

endmodule

bind fetch_top fetch_assertions u_assertions (
    .clk               (clk),
    .rst               (rst),
    .stall_backend     (stall_backend),
    .queue_almost_full (queue_almost_full),
    .flush             (flush),
    .correct_target    (correct_target),
    .s1_valid          (s1_valid),
    .s1_pc             (s1_pc),
    .hold              (hold),
    .fetch_valid       (fetch_valid),
    .fetch_pc          (fetch_pc),
    .fetch_valid_1     (fetch_valid_1),
    .fetch_pc_1        (fetch_pc_1)
);

/* bench/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

    localparam int NROWS = 7;
    localparam int ROW_CYCLES = 20;
    localparam int EXP_MAX = 64;
    localparam int TIMEOUT_CYCLES = NROWS * 25 + 50;
    localparam instr_t NOP = 32'h00000013;

    logic clk = 1'b0;
    logic rst;
    logic stall_backend;
    logic queue_almost_full;
    logic branch_mispredict;
    logic flush;
    addr_t correct_target;
    addr_t icache_addr;
    logic [3:0] icache_rmask;
    instr_t icache_rdata;
    logic icache_resp;
    addr_t icache_addr_1;
    logic [3:0] icache_rmask_1;
    instr_t icache_rdata_1;
    logic icache_resp_1;
    instr_t fetch_instr;
    addr_t fetch_pc;
    logic fetch_valid;
    logic fetch_predicted_taken;
    addr_t fetch_predicted_target;
    instr_t fetch_instr_1;
    addr_t fetch_pc_1;
    logic fetch_valid_1;
    logic fetch_predicted_taken_1;
    addr_t fetch_predicted_target_1;

    // Scenario table, one entry per row
    addr_t row_start [NROWS];
    instr_t row_prog [NROWS][8];
    logic [15:0] row_stall [NROWS];
    logic row_queue [NROWS];
    int row_min [NROWS];
    // Mispredict cycle inside the row, 0 when the row has none
    int row_mp_cycle [NROWS];
    addr_t row_mp_target [NROWS];

    // Expected slot stream
    addr_t exp_pc [EXP_MAX];
    instr_t exp_instr [EXP_MAX];
    logic exp_taken [EXP_MAX];
    addr_t exp_target [EXP_MAX];
    int exp_len;
    int exp_idx;

    int errors = 0;
    int row_slots;
    int total_slots = 0;
    int cycle_count = 0;
    logic [31:0] rnd;
    int r;
    int i;

    always #2 clk = ~clk;

    fetch_top u_fetch_top (.*);

    icache_model u_icache (
        .clk     (clk),
        .rst     (rst),
        .addr    (icache_addr),
        .rmask   (icache_rmask),
        .rdata   (icache_rdata),
        .resp    (icache_resp),
        .addr_1  (icache_addr_1),
        .rmask_1 (icache_rmask_1),
        .rdata_1 (icache_rdata_1),
        .resp_1  (icache_resp_1)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Words 4 to 7 are addi x2,x2,k so each program has eight distinct words
    task automatic set_row(input int n, input addr_t start, input instr_t w0, input instr_t w1,
                           input instr_t w2, input instr_t w3, input logic [15:0] stall,
                           input logic queue, input int min_slots, input int mp_cycle,
                           input addr_t mp_target);
        row_start[n] = start;
        row_prog[n][0] = w0;
        row_prog[n][1] = w1;
        row_prog[n][2] = w2;
        row_prog[n][3] = w3;
        for (int k = 4; k < 8; k++)
            row_prog[n][k] = 32'h00010113 + (k << 20);
        row_stall[n] = stall;
        row_queue[n] = queue;
        row_min[n] = min_slots;
        row_mp_cycle[n] = mp_cycle;
        row_mp_target[n] = mp_target;
    endtask

    // Backward branches and JAL taken, JALR and everything else fall through
    task automatic static_predict(input instr_t w, input addr_t pc, output logic taken,
                                  output addr_t target);
        int off;
        taken = 1'b0;
        target = pc + 4;
        case (w[6:0])
            7'h63: begin
                off = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
                taken = (off < 0);
                target = pc + off;
            end
            7'h6F: begin
                off = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
                taken = 1'b1;
                target = pc + off;
            end
            default: ;
        endcase
    endtask

    task automatic push_expected(input addr_t pc, input instr_t w, input logic taken,
                                 input addr_t target);
        if (exp_len < EXP_MAX) begin
            exp_pc[exp_len] = pc;
            exp_instr[exp_len] = w;
            exp_taken[exp_len] = taken;
            exp_target[exp_len] = target;
            exp_len++;
        end
    endtask

    // Walk the program from start with the pairing and next-PC rules
    task automatic build_expected(input addr_t start);
        addr_t pc;
        instr_t w0;
        instr_t w1;
        logic t0;
        logic t1;
        addr_t g0;
        addr_t g1;
        logic pair;
        exp_len = 0;
        exp_idx = 0;
        pc = start;
        while (exp_len < EXP_MAX) begin
            w0 = u_icache.word_at(pc);
            static_predict(w0, pc, t0, g0);
            push_expected(pc, w0, t0, g0);
            // Slot 1 only when PC is not the last word of its line
            pair = (pc[4:0] != 5'h1C) && !queue_almost_full;
            if (t0) begin
                pc = g0;
            end else if (pair) begin
                w1 = u_icache.word_at(pc + 4);
                static_predict(w1, pc + 4, t1, g1);
                push_expected(pc + 4, w1, t1, g1);
                pc = t1 ? g1 : pc + 8;
            end else begin
                pc = pc + 4;
            end
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    task automatic check_slot(input addr_t pc, input instr_t instr, input logic taken,
                              input addr_t target);
        if (exp_idx >= exp_len) begin
            $display("Output at %0t ran past the end of the expected stream", $time);
            errors++;
        end else begin
            if (pc !== exp_pc[exp_idx])
                report_mismatch("slot pc", pc, exp_pc[exp_idx]);
            if (instr !== exp_instr[exp_idx])
                report_mismatch("slot instruction", instr, exp_instr[exp_idx]);
            if (taken !== exp_taken[exp_idx])
                report_mismatch("predicted taken", taken, exp_taken[exp_idx]);
            if (exp_taken[exp_idx] && target !== exp_target[exp_idx])
                report_mismatch("predicted target", target, exp_target[exp_idx]);
            exp_idx++;
        end
        row_slots++;
    endtask

    // Mid-cycle look at the outputs, slot 0 before slot 1
    task automatic sample_cycle();
        logic [3:0] want_mask_1;
        if (stall_backend && fetch_valid)
            report_mismatch("fetch_valid under stall", fetch_valid, 0);
        if ((flush || branch_mispredict) && fetch_valid)
            report_mismatch("fetch_valid on redirect", fetch_valid, 0);
        if (fetch_valid_1 && !fetch_valid)
            report_mismatch("fetch_valid without slot 0", fetch_valid, 1);
        if (queue_almost_full && fetch_valid_1)
            report_mismatch("fetch_valid_1 with queue almost full", fetch_valid_1, 0);
        // Port 1 reads only while port 0 does and only inside its line
        want_mask_1 = (icache_rmask != 4'b0000 && icache_addr[4:0] != 5'h1C)
                      ? 4'b1111 : 4'b0000;
        if (icache_rmask_1 !== want_mask_1)
            report_mismatch("icache_rmask_1", icache_rmask_1, want_mask_1);
        if (icache_rmask_1 != 4'b0000 && icache_addr_1 !== icache_addr + 32'd4)
            report_mismatch("icache_addr_1", icache_addr_1, icache_addr + 32'd4);
        if (fetch_valid)
            check_slot(fetch_pc, fetch_instr, fetch_predicted_taken, fetch_predicted_target);
        if (fetch_valid_1)
            check_slot(fetch_pc_1, fetch_instr_1, fetch_predicted_taken_1,
                       fetch_predicted_target_1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after the cycle limit of %0d", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        stall_backend = 1'b0;
        queue_almost_full = 1'b0;
        branch_mispredict = 1'b0;
        flush = 1'b0;
        correct_target = '0;
        rnd = 32'd43;
        u_icache.prog_base = '0;
        for (int k = 0; k < 8; k++)
            u_icache.prog[k] = NOP;

        // Straight line, line end, branches, JAL in slot 1, stalls, mispredict
        set_row(0, 32'h00001000, 32'h00100093, 32'h00208113, 32'h00310193, 32'h00418213,
                16'h0000, 1'b0, 38, 0, '0);
        set_row(1, 32'h0000201C, NOP, 32'h00100093, 32'h00208113, NOP,
                16'h0000, 1'b0, 37, 0, '0);
        set_row(2, 32'h00003000, 32'h00000863, NOP, 32'hFE000CE3, NOP,
                16'h0000, 1'b0, 29, 0, '0);
        set_row(3, 32'h00004000, NOP, 32'h1000006F, NOP, NOP,
                16'h0000, 1'b0, 37, 0, '0);
        set_row(4, 32'h00005000, NOP, 32'h00100093, NOP, 32'h00208113,
                16'hFFFE, 1'b1, 4, 0, '0);
        set_row(5, 32'h00005800, 32'h00100093, NOP, 32'h00208113, NOP,
                16'h6DB6, 1'b0, 8, 0, '0);
        set_row(6, 32'h00006000, NOP, NOP, 32'h00100093, NOP,
                16'h0000, 1'b0, 36, 8, 32'h00007010);

        repeat (4) @(posedge clk);
        // Nothing leaves the front end while reset is held
        @(negedge clk);
        if (fetch_valid !== 1'b0 || fetch_valid_1 !== 1'b0)
            report_mismatch("fetch_valid pair in reset", {fetch_valid, fetch_valid_1}, 0);
        if (fetch_predicted_taken !== 1'b0 || fetch_predicted_taken_1 !== 1'b0)
            report_mismatch("predicted taken pair in reset",
                            {fetch_predicted_taken, fetch_predicted_taken_1}, 0);
        @(posedge clk);
        #1 rst = 1'b0;
        // First request out of reset reads the reset PC
        @(negedge clk);
        if (icache_addr !== RESET_PC)
            report_mismatch("icache_addr after reset", icache_addr, RESET_PC);
        if (icache_rmask !== 4'b1111)
            report_mismatch("icache_rmask after reset", icache_rmask, 4'b1111);

        for (r = 0; r < NROWS; r++) begin
            row_slots = 0;
            @(posedge clk);
            #1;
            u_icache.prog_base = row_start[r];
            for (int k = 0; k < 8; k++)
                u_icache.prog[k] = row_prog[r][k];
            queue_almost_full = row_queue[r];
            correct_target = row_start[r];
            build_expected(row_start[r]);
            for (i = 0; i < ROW_CYCLES; i++) begin
                if (i > 0) begin
                    @(posedge clk);
                    #1;
                end
                flush = (i == 0);
                branch_mispredict = (row_mp_cycle[r] != 0) && (i == row_mp_cycle[r]);
                // Stream restarts at the corrected target
                if (branch_mispredict) begin
                    correct_target = row_mp_target[r];
                    build_expected(row_mp_target[r]);
                end
                rnd = xorshift(rnd);
                stall_backend = (i < 16) ? (row_stall[r][i] & rnd[9]) : 1'b0;
                @(negedge clk);
                sample_cycle();
            end
            if (row_slots < row_min[r]) begin
                $display("Row %0d gave %0d slots, fewer than the %0d it should",
                         r, row_slots, row_min[r]);
                errors++;
            end
            total_slots += row_slots;
            $display("Row %0d done: start %h, %0d slots, %0d errors so far",
                     r, row_start[r], row_slots, errors);
        end

        $display("Rows %0d, slots checked %0d, errors %0d", NROWS, total_slots, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb.f */
design/fetch_pkg.sv
design/fetch_request.sv
design/slot_predecode.sv
design/fetch_capture.sv
design/fetch_top.sv
bench/icache_model.sv
bench/fetch_assertions.sv
bench/tb_fetch.sv
